//--- sim/mem_ctrl_cases.hex
// columns: fetch_addr data_op(0 load, 1 store) data_addr store_data d_enable
// one access per line, all values hex
0100 1 0040 1111 1 // fetch miss and store miss together
0100 1 0041 2222 1
0101 0 0040 0000 1 // load of a stored word, refill
0101 0 0040 0000 1 // repeat hits
0102 1 0041 3333 1 // store to a cached line
0102 0 0041 0000 1
0102 1 0085 4444 1 // store to an uncached line
0103 0 0085 0000 1
0104 1 0800 a001 1 // fill a region for later fetches
0104 1 0801 a002 1
0104 1 0802 a003 1
0104 1 0803 a004 1
0105 1 0048 b0b0 1 // same index, two tags
0105 1 0448 c0c0 1
0106 0 0048 0000 1
0106 0 0448 0000 1
0106 0 0048 0000 1
0106 0 0448 0000 1
0800 0 0802 0000 1 // fetch and data miss together
0801 0 0041 0000 1
0802 1 0041 dead 0 // data port parked
0803 0 0000 0000 0
0041 0 0000 0000 0
0041 0 0041 0000 1

//--- mem_ctrl_top.f
rtl/mem_types_pkg.sv
rtl/mem_ctrl_pkg.sv
rtl/cache_array.sv
rtl/cache_bank.sv
rtl/main_memory.sv
rtl/fill_fsm.sv
rtl/mem_ctrl_top.sv
sim/mem_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the memory controller testbench
SIM  := obj_dir/Vmem_ctrl_tb
SRCS := $(shell cat mem_ctrl_top.f)

.PHONY: all run clean

all: run

$(SIM): mem_ctrl_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module mem_ctrl_tb \
		-Mdir obj_dir -f mem_ctrl_top.f

run: $(SIM) sim/mem_ctrl_cases.hex
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- sim/mem_ctrl_tb.sv
// mem_ctrl_tb: case-file driven testbench for both cache ports, reference memory, checks
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_tb import mem_types_pkg::*; ();

	localparam int CLK_PERIOD      = 8;
	localparam int RST_CYCLES      = 3;
	localparam int MAX_CASES       = 64;
	localparam int CASE_FIELDS     = 5;  // fetch addr, op, data addr, store data, d_enable
	localparam int CYCLES_PER_CASE = 40; // generous bound for two refills and a store

	logic  clk;
	logic  rst_n;
	addr_t if_addr;
	addr_t dm_addr;
	logic  dm_we;
	word_t dm_wdata;
	logic  d_enable;
	word_t if_rdata;
	word_t dm_rdata;
	logic  if_miss;
	logic  dm_miss;

	logic [15:0] case_mem [MAX_CASES*CASE_FIELDS]; // flat, CASE_FIELDS words per case
	word_t       ref_mem [MEM_WORDS];              // expected memory image, built from stores
	logic        ref_written [MEM_WORDS];          // only written words are checked
	int          num_cases;
	int          check_count;
	int          error_count;

	mem_ctrl_top u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_addr  (if_addr),
		.dm_addr  (dm_addr),
		.dm_we    (dm_we),
		.dm_wdata (dm_wdata),
		.d_enable (d_enable),
		.if_rdata (if_rdata),
		.dm_rdata (dm_rdata),
		.if_miss  (if_miss),
		.dm_miss  (dm_miss)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// compare one returned word against the reference image
	task automatic check_word(input int idx, input string port, input addr_t addr,
			input word_t got);
		check_count++;
		if (got !== ref_mem[addr]) begin
			error_count++;
			$display("Mismatch at %0t: case %0d %s read of %h returned %h, expected %h",
				$time, idx, port, addr, got, ref_mem[addr]);
		end
	endtask

	// apply one case on the falling edge and wait until every port in use is released
	task automatic run_case(input int idx);
		int    base;
		int    cyc;
		int    if_low_cyc;
		int    dm_low_cyc;
		logic  both_missed;
		logic  done;
		addr_t f_addr;
		addr_t d_addr;
		word_t d_data;
		logic  d_store;
		logic  d_en;
		base     = idx * CASE_FIELDS;
		f_addr   = case_mem[base];
		d_store  = case_mem[base+1][0];
		d_addr   = case_mem[base+2];
		d_data   = case_mem[base+3];
		d_en     = case_mem[base+4][0];
		if_addr  = f_addr;
		dm_we    = d_store;
		dm_addr  = d_addr;
		dm_wdata = d_data;
		d_enable = d_en;
		cyc         = 0;
		if_low_cyc  = -1;
		dm_low_cyc  = -1;
		both_missed = 1'b0;
		done        = 1'b0;
		while (!done) begin
			#(CLK_PERIOD/2 - 1); // settled, just ahead of the rising edge
			if (cyc == 0) begin
				both_missed = if_miss && dm_miss && d_en;
			end
			if (!d_en && dm_miss) begin
				error_count++;
				$display("Error at %0t: case %0d raised dm_miss while d_enable was low",
					$time, idx);
			end
			if (!if_miss && if_low_cyc < 0) if_low_cyc = cyc;
			if (!dm_miss && dm_low_cyc < 0) dm_low_cyc = cyc;
			if (!if_miss && !(d_en && dm_miss)) begin
				done = 1'b1; // the coming rising edge completes the access
				if (ref_written[f_addr]) check_word(idx, "fetch", f_addr, if_rdata);
				if (d_en && !d_store && ref_written[d_addr]) begin
					check_word(idx, "data", d_addr, dm_rdata);
				end
				if (d_en && d_store) begin
					ref_mem[d_addr]     = d_data; // write-through, memory always updated
					ref_written[d_addr] = 1'b1;
				end
				if (both_missed && dm_low_cyc < if_low_cyc) begin
					error_count++;
					$display("Error at %0t: case %0d served the data port before the fetch port",
						$time, idx);
				end
			end
			@(negedge clk); // passes the rising edge, next drive point
			cyc++;
		end
	endtask

	initial begin : main_seq
		int n;
		rst_n       = 1'b0;
		if_addr     = '0;
		dm_addr     = '0;
		dm_we       = 1'b0;
		dm_wdata    = '0;
		d_enable    = 1'b0;
		num_cases   = 0;
		check_count = 0;
		error_count = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i]     = '0;
			ref_written[i] = 1'b0;
		end
		for (int i = 0; i < MAX_CASES*CASE_FIELDS; i++) begin
			case_mem[i] = 16'hffff; // the op column never holds ffff, marks the end
		end
		$readmemh("sim/mem_ctrl_cases.hex", case_mem);
		n = 0;
		while (n < MAX_CASES && case_mem[n*CASE_FIELDS+1] != 16'hffff) n++;
		num_cases = n; // set once, the watchdog sizes itself from it
		if (num_cases == 0) begin
			error_count++;
			$display("Error: no cases were loaded from sim/mem_ctrl_cases.hex");
		end
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end
		$display("Summary: %0d cases, %0d checks, %0d errors", num_cases, check_count,
			error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog, bound scales with the number of cases
	initial begin : watchdog
		wait (num_cases > 0);
		repeat (num_cases * CYCLES_PER_CASE + RST_CYCLES) @(posedge clk);
		$display("Error: run timed out after %0d cycles, a miss level never dropped",
			num_cases * CYCLES_PER_CASE + RST_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl_top.sv
// mem_ctrl_top: fetch and data cache banks, fill controller and main memory
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top import mem_types_pkg::*, mem_ctrl_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire addr_t if_addr,  // fetch port, read only
	input  wire addr_t dm_addr,
	input  wire logic  dm_we,
	input  wire word_t dm_wdata,
	input  wire logic  d_enable, // low parks the data port
	output word_t      if_rdata,
	output word_t      dm_rdata,
	output logic       if_miss,
	output logic       dm_miss
);

	logic      if_hit;
	logic      dm_hit;
	cache_wr_t if_wr;
	cache_wr_t dm_wr;
	mem_req_t  mem_req; // driven by the fill controller only
	mem_rsp_t  mem_rsp; // driven by main memory only

	cache_bank u_icache (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (if_addr),
		.wr    (if_wr),
		.hit   (if_hit),
		.rdata (if_rdata)
	);

	cache_bank u_dcache (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (dm_addr),
		.wr    (dm_wr),
		.hit   (dm_hit),
		.rdata (dm_rdata)
	);

	fill_fsm u_fill (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_addr  (if_addr),
		.dm_addr  (dm_addr),
		.dm_we    (dm_we),
		.dm_wdata (dm_wdata),
		.d_enable (d_enable),
		.if_hit   (if_hit),
		.dm_hit   (dm_hit),
		.if_wr    (if_wr),
		.dm_wr    (dm_wr),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp),
		.if_miss  (if_miss),
		.dm_miss  (dm_miss)
	);

	main_memory u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mem_req),
		.rsp   (mem_rsp)
	);

endmodule

`default_nettype wire

//--- rtl/fill_fsm.sv
// fill_fsm: miss arbitration, block refill, write-through stores and stall levels
`timescale 1ns/1ps
`default_nettype none

module fill_fsm import mem_types_pkg::*, mem_ctrl_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire addr_t    if_addr,
	input  wire addr_t    dm_addr,
	input  wire logic     dm_we,
	input  wire word_t    dm_wdata,
	input  wire logic     d_enable,
	input  wire logic     if_hit,
	input  wire logic     dm_hit,
	output cache_wr_t     if_wr,
	output cache_wr_t     dm_wr,
	output mem_req_t      mem_req,
	input  wire mem_rsp_t mem_rsp,
	output logic          if_miss,
	output logic          dm_miss
);

	typedef enum logic [1:0] {
		S_IDLE,  // wait for a miss or a store
		S_FILL,  // issue and collect the block reads
		S_TAG,   // validate the refilled line
		S_STORE  // one cycle of memory write
	} state_t;

	state_t              state_q, state_d;
	logic [OFFSET_W:0]   issue_q;      // reads issued, msb set once the whole block is out
	logic [OFFSET_W-1:0] recv_q;       // offset for the next returning word
	logic                side_q;       // 1 fetch bank owns the refill, 0 data bank
	logic                store_done_q; // store written, release dm_miss for one cycle
	logic                dm_load_miss;
	logic                dm_store_pend;
	addr_t               fill_addr;
	cache_wr_t           fill_wr;
	cache_wr_t           store_wr;

	// stall levels, the banks only report hit
	assign if_miss       = !if_hit; // fetch port always reads
	assign dm_load_miss  = d_enable && !dm_we && !dm_hit;
	assign dm_store_pend = d_enable && dm_we && !store_done_q;
	assign dm_miss       = dm_load_miss || dm_store_pend;

	assign fill_addr = side_q ? if_addr : dm_addr; // port holds its address while stalled

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (if_miss || dm_load_miss) begin
					state_d = S_FILL; // fetch side wins, see side_q
				end else if (dm_store_pend) begin
					state_d = S_STORE;
				end
			end
			S_FILL: begin
				if (mem_rsp.valid && (&recv_q)) begin
					state_d = S_TAG; // last word of the block is in
				end
			end
			S_TAG:   state_d = S_IDLE;
			S_STORE: state_d = S_IDLE;
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q      <= S_IDLE;
			issue_q      <= '0;
			recv_q       <= '0;
			side_q       <= 1'b0;
			store_done_q <= 1'b0;
		end else begin
			state_q      <= state_d;
			store_done_q <= (state_q == S_STORE); // store completes the cycle after the write
			case (state_q)
				S_IDLE: begin
					issue_q <= '0;
					recv_q  <= '0;
					side_q  <= if_miss; // fetch first when both miss
				end
				S_FILL: begin
					if (!issue_q[OFFSET_W]) begin
						issue_q <= issue_q + 1'b1;
					end
					if (mem_rsp.valid) begin
						recv_q <= recv_q + 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// memory request, reads overlap so up to MEM_LATENCY are in flight
	always_comb begin
		mem_req = '0;
		if (state_q == S_FILL && !issue_q[OFFSET_W]) begin
			mem_req.en   = 1'b1;
			mem_req.addr = {fill_addr[ADDR_W-1:OFFSET_W], issue_q[OFFSET_W-1:0]};
		end else if (state_q == S_STORE) begin
			mem_req.en   = 1'b1; // write-through, always reaches memory
			mem_req.we   = 1'b1;
			mem_req.addr = dm_addr;
			mem_req.data = dm_wdata;
		end
	end

	// refill writes to whichever bank owns the fill
	always_comb begin
		fill_wr = '{op: OP_NONE, offset: recv_q, data: mem_rsp.data};
		if (state_q == S_FILL && mem_rsp.valid) begin
			fill_wr.op = OP_WORD;
		end else if (state_q == S_TAG) begin
			fill_wr.op = OP_TAG;
		end
	end

	// no-allocate, cache only updated when the line is present
	assign store_wr = '{op:     dm_hit ? OP_WORD : OP_NONE,
	                    offset: dm_addr[OFFSET_W-1:0],
	                    data:   dm_wdata};

	assign if_wr = side_q ? fill_wr : CACHE_WR_IDLE;
	assign dm_wr = (state_q == S_STORE) ? store_wr :
	               (!side_q)            ? fill_wr  : CACHE_WR_IDLE;

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
// main_memory: 64K word array with single-cycle writes and fixed-latency pipelined reads
`timescale 1ns/1ps
`default_nettype none

module main_memory import mem_types_pkg::*, mem_ctrl_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire mem_req_t req,
	output mem_rsp_t      rsp
);

	word_t            mem [MEM_WORDS]; // no defined contents at power-up
	logic [MEM_LATENCY-1:0] vld_q;     // read strobes in flight
	word_t            dat_q [MEM_LATENCY];

	// write lands on the request cycle
	always_ff @(posedge clk) begin
		if (req.en && req.we) begin
			mem[req.addr] <= req.data;
		end
	end

	// data side of the read pipe, sampled every cycle and qualified by vld_q
	always_ff @(posedge clk) begin
		dat_q[0] <= mem[req.addr];
		for (int i = 1; i < MEM_LATENCY; i++) begin
			dat_q[i] <= dat_q[i-1];
		end
	end

	// one stage per cycle of latency, several reads may be outstanding
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[MEM_LATENCY-2:0], req.en && !req.we};
		end
	end

	assign rsp = '{valid: vld_q[MEM_LATENCY-1], data: dat_q[MEM_LATENCY-1]};

endmodule

`default_nettype wire

//--- rtl/cache_bank.sv
// cache_bank: direct-mapped cache with tag store, data store, tag compare and hit
`timescale 1ns/1ps
`default_nettype none

module cache_bank import mem_types_pkg::*, mem_ctrl_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire addr_t     addr,  // port address, held while the port stalls
	input  wire cache_wr_t wr,    // fill words, tag fill or store update
	output logic           hit,
	output word_t          rdata
);

	logic [TAG_W-1:0]    addr_tag;
	logic [INDEX_W-1:0]  addr_index;
	logic [OFFSET_W-1:0] addr_offset;

	tag_entry_t tag_rd;    // stored entry of the addressed line
	tag_entry_t tag_wdata;
	logic       tag_we;
	logic       data_we;

	// tag | index | offset
	assign {addr_tag, addr_index, addr_offset} = addr;

	assign tag_we    = (wr.op == OP_TAG);
	assign data_we   = (wr.op == OP_WORD);
	assign tag_wdata = '{valid: 1'b1, tag: addr_tag}; // tag op always validates

	// one entry per line
	cache_array #(
		.entry_t (tag_entry_t),
		.DEPTH   (LINES)
	) u_tags (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (tag_we),
		.waddr (addr_index),
		.wdata (tag_wdata),
		.raddr (addr_index),
		.rdata (tag_rd)
	);

	// one entry per word, addressed as {line, word}
	cache_array #(
		.entry_t (word_t),
		.DEPTH   (LINES * BLOCK_WORDS)
	) u_data (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (data_we),
		.waddr ({addr_index, wr.offset}), // fill walks the offsets of the current line
		.wdata (wr.data),
		.raddr ({addr_index, addr_offset}),
		.rdata (rdata)
	);

	assign hit = tag_rd.valid && (tag_rd.tag == addr_tag);

endmodule

`default_nettype wire

//--- rtl/cache_array.sv
// cache_array: typed storage with synchronous write, asynchronous read and reset clear
`timescale 1ns/1ps
`default_nettype none

module cache_array import mem_types_pkg::*; #(
	parameter type entry_t = word_t, // tag_entry_t for tags, word_t for data
	parameter int  DEPTH   = LINES
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     we,
	input  wire logic [$clog2(DEPTH)-1:0] waddr,
	input  wire entry_t                   wdata,
	input  wire logic [$clog2(DEPTH)-1:0] raddr,
	output entry_t                        rdata
);

	entry_t mem_q [DEPTH];

	// reset wipes every entry so the tag store comes up all invalid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else if (we) begin
			mem_q[waddr] <= wdata;
		end
	end

	assign rdata = mem_q[raddr]; // async read, hit data in the same cycle

endmodule

`default_nettype wire

//--- rtl/mem_ctrl_pkg.sv
// fill operation enum, cache write, memory request and memory response structs
`default_nettype none

package mem_ctrl_pkg;
	import mem_types_pkg::*;

	// what a cache bank does with its write struct this cycle
	typedef enum logic [1:0] {
		OP_NONE = 2'd0, // read only
		OP_WORD = 2'd1, // write one data word at wr.offset
		OP_TAG  = 2'd2  // mark the current line valid with the current tag
	} fill_op_t;

	typedef struct packed {
		fill_op_t            op;
		logic [OFFSET_W-1:0] offset; // word within the line addressed by the port
		word_t               data;
	} cache_wr_t;

	localparam cache_wr_t CACHE_WR_IDLE = '{op: OP_NONE, offset: '0, data: '0};

	typedef struct packed {
		logic  en;   // request strobe, one per cycle
		logic  we;   // 1 write, 0 read
		addr_t addr;
		word_t data; // write data
	} mem_req_t;

	typedef struct packed {
		logic  valid; // read data strobe, MEM_LATENCY after the request
		word_t data;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/mem_types_pkg.sv
// memory geometry constants, address and data word types, tag store entry
`default_nettype none

package mem_types_pkg;

	localparam int ADDR_W      = 16;    // word address width
	localparam int WORD_W      = 16;    // data word width
	localparam int OFFSET_W    = 2;     // word offset within a line
	localparam int INDEX_W     = 4;     // line index
	localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W; // 10 bits left for the tag
	localparam int LINES       = 1 << INDEX_W;   // 16 lines per cache
	localparam int BLOCK_WORDS = 1 << OFFSET_W;  // 4 words per line
	localparam int MEM_WORDS   = 1 << ADDR_W;    // full 64K word space
	localparam int MEM_LATENCY = 4;     // cycles from read request to response

	typedef logic [ADDR_W-1:0] addr_t; // word address, no byte lanes
	typedef logic [WORD_W-1:0] word_t;

	// one entry of the tag store
	// valid is cleared by reset and set by a tag fill
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

`default_nettype wire
